//--- design/edm_consts.svh
`ifndef EDM_CONSTS_SVH
`define EDM_CONSTS_SVH

// width of every pulse parameter word
`define PARAM_W 16

// ack synchronizer depth
`define SYNC_STAGES 3

// peak current clamp in current command units
`define IP_MAX 16'd4000

`endif

//--- design/edm_pkg.sv
package edm_pkg;

    // waveform code taken from the low 2 bits of the host waveform word
    typedef enum logic [1:0]
    {
        WAVE_RECT      = 2'd0, // step equals target
        WAVE_RAMP_FAST = 2'd1, // step is target / 4
        WAVE_RAMP_SLOW = 2'd2, // step is target / 16
        WAVE_RSVD      = 2'd3  // handled as rectangular
    } waveform_e;

    // discharge timer phase
    typedef enum logic [1:0]
    {
        PH_IDLE = 2'd0,
        PH_ON   = 2'd1,
        PH_OFF  = 2'd2
    } phase_e;

endpackage

//--- design/pulse_param_if.sv
`timescale 1ns/1ps
`include "edm_consts.svh"

interface pulse_param_if import edm_pkg::*; ();

    logic                run;      // machine running
    logic [`PARAM_W-1:0] ton;      // on time in clk cycles
    logic [`PARAM_W-1:0] toff;     // off time in clk cycles
    logic [`PARAM_W-1:0] ip;       // requested peak current
    waveform_e           waveform;

    modport src
    (
        output run, ton, toff, ip, waveform
    );

    modport snk
    (
        input run, ton, toff, ip, waveform
    );

endinterface

//--- design/param_latch.sv
`timescale 1ns/1ps
`include "edm_consts.svh"

module param_latch
#(
    parameter type T = logic [`PARAM_W-1:0]
)
(
    input  logic clk,
    input  logic rst_n,
    input  logic ack,
    input  T     data_async,
    output T     data
);

    logic [`SYNC_STAGES-1:0] ack_sync;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            ack_sync <= '0;
        else
            ack_sync <= {ack_sync[`SYNC_STAGES-2:0], ack};
    end

    // host keeps the word stable while ack is high
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            data <= T'(0);
        else if (ack_sync[`SYNC_STAGES-1])
            data <= data_async;
    end

endmodule

//--- design/param_sync.sv
`timescale 1ns/1ps
`include "edm_consts.svh"

module param_sync import edm_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start_ack,
    input  logic                stop_ack,
    input  logic                ton_ack,
    input  logic                toff_ack,
    input  logic                ip_ack,
    input  logic                wave_ack,
    input  logic [`PARAM_W-1:0] ton_async,
    input  logic [`PARAM_W-1:0] toff_async,
    input  logic [`PARAM_W-1:0] ip_async,
    input  logic [`PARAM_W-1:0] wave_async,
    pulse_param_if.src          prm
);

    logic [`SYNC_STAGES-1:0] start_sync;
    logic [`SYNC_STAGES-1:0] stop_sync;
    logic                    run;
    waveform_e               wave_code;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            start_sync <= '0;
            stop_sync  <= '0;
        end
        else
        begin
            start_sync <= {start_sync[`SYNC_STAGES-2:0], start_ack};
            stop_sync  <= {stop_sync[`SYNC_STAGES-2:0], stop_ack};
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            run <= 1'b0;
        else if (start_sync[`SYNC_STAGES-1]) // start wins over stop
            run <= 1'b1;
        else if (stop_sync[`SYNC_STAGES-1])
            run <= 1'b0;
    end

    assign prm.run   = run;
    assign wave_code = waveform_e'(wave_async[1:0]); // upper bits ignored

    param_latch u_ton  (.clk, .rst_n, .ack(ton_ack),  .data_async(ton_async),  .data(prm.ton));
    param_latch u_toff (.clk, .rst_n, .ack(toff_ack), .data_async(toff_async), .data(prm.toff));
    param_latch u_ip   (.clk, .rst_n, .ack(ip_ack),   .data_async(ip_async),   .data(prm.ip));

    param_latch #(.T(waveform_e)) u_wave
    (
        .clk        (clk),
        .rst_n      (rst_n),
        .ack        (wave_ack),
        .data_async (wave_code),
        .data       (prm.waveform)
    );

endmodule

//--- design/pulse_timer.sv
`timescale 1ns/1ps
`include "edm_consts.svh"

module pulse_timer import edm_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    pulse_param_if.snk prm,
    output logic       gate
);

    phase_e              state;
    logic [`PARAM_W-1:0] cnt;

    // phase length minus one where a zero width counts as one cycle
    function automatic logic [`PARAM_W-1:0] len_m1(input logic [`PARAM_W-1:0] v);
        return (v == '0) ? '0 : v - 1'b1;
    endfunction

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state <= PH_IDLE;
            cnt   <= '0;
            gate  <= 1'b0;
        end
        else if (!prm.run)
        begin
            state <= PH_IDLE;
            cnt   <= '0;
            gate  <= 1'b0;
        end
        else
        begin
            case (state)
                PH_IDLE, PH_OFF:
                begin
                    if (state == PH_IDLE || cnt == '0)
                    begin
                        state <= PH_ON;
                        cnt   <= len_m1(prm.ton); // ton sampled on entry
                        gate  <= 1'b1;
                    end
                    else
                        cnt <= cnt - 1'b1;
                end
                PH_ON:
                begin
                    if (cnt == '0)
                    begin
                        state <= PH_OFF;
                        cnt   <= len_m1(prm.toff);
                        gate  <= 1'b0;
                    end
                    else
                        cnt <= cnt - 1'b1;
                end
                default:
                begin
                    state <= PH_IDLE;
                    gate  <= 1'b0;
                end
            endcase
        end
    end

    a_gate_on_only: assert property (@(posedge clk) disable iff (!rst_n)
        gate |-> state == PH_ON);

endmodule

//--- design/current_profile.sv
`timescale 1ns/1ps
`include "edm_consts.svh"

module current_profile import edm_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    pulse_param_if.snk          prm,
    output logic [`PARAM_W-1:0] target,
    output logic [`PARAM_W-1:0] step
);

    logic [`PARAM_W-1:0] target_c;
    logic [`PARAM_W-1:0] step_c;

    always_comb
    begin
        target_c = (prm.ip > `IP_MAX) ? `IP_MAX : prm.ip;
        case (prm.waveform)
            WAVE_RAMP_FAST: step_c = target_c >> 2;
            WAVE_RAMP_SLOW: step_c = target_c >> 4;
            default:        step_c = target_c; // rect and reserved
        endcase
        if (target_c != '0 && step_c == '0)
            step_c = 'd1; // small targets still ramp up
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            target <= '0;
            step   <= '0;
        end
        else
        begin
            target <= target_c;
            step   <= step_c;
        end
    end

    a_target_clamped: assert property (@(posedge clk) disable iff (!rst_n)
        target <= `IP_MAX);

endmodule

//--- design/pulse_driver.sv
`timescale 1ns/1ps
`include "edm_consts.svh"

module pulse_driver
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                gate,
    input  logic [`PARAM_W-1:0] target,
    input  logic [`PARAM_W-1:0] step,
    output logic                gate_out,
    output logic [`PARAM_W-1:0] current_cmd,
    output logic [`PARAM_W-1:0] pulse_count
);

    logic [`PARAM_W:0]   ramp_sum;
    logic [`PARAM_W-1:0] cmd_next;

    always_comb
    begin
        ramp_sum = {1'b0, current_cmd} + {1'b0, step};
        if (!gate)
            cmd_next = '0;
        else if (ramp_sum > {1'b0, target})
            cmd_next = target; // saturate
        else
            cmd_next = ramp_sum[`PARAM_W-1:0];
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            gate_out    <= 1'b0;
            current_cmd <= '0;
            pulse_count <= '0;
        end
        else
        begin
            gate_out    <= gate;
            current_cmd <= cmd_next;
            if (gate && !gate_out) // gate_out is last cycle's gate
                pulse_count <= pulse_count + 1'b1;
        end
    end

    a_cmd_le_target: assert property (@(posedge clk) disable iff (!rst_n)
        $stable(target) |-> current_cmd <= target);

    a_cmd_off_gap: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(gate_out) |-> current_cmd == '0);

endmodule

//--- design/edm_pulse_top.sv
`timescale 1ns/1ps
`include "edm_consts.svh"

module edm_pulse_top
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start_ack,
    input  logic                stop_ack,
    input  logic                ton_ack,
    input  logic                toff_ack,
    input  logic                ip_ack,
    input  logic                wave_ack,
    input  logic [`PARAM_W-1:0] ton_async,
    input  logic [`PARAM_W-1:0] toff_async,
    input  logic [`PARAM_W-1:0] ip_async,
    input  logic [`PARAM_W-1:0] wave_async,
    output logic                running,
    output logic                gate_out,
    output logic [`PARAM_W-1:0] current_cmd,
    output logic [`PARAM_W-1:0] pulse_count
);

    pulse_param_if prm ();

    logic                gate;
    logic [`PARAM_W-1:0] target;
    logic [`PARAM_W-1:0] step;

    param_sync u_param_sync
    (
        .clk, .rst_n,
        .start_ack, .stop_ack, .ton_ack, .toff_ack, .ip_ack, .wave_ack,
        .ton_async, .toff_async, .ip_async, .wave_async,
        .prm        (prm.src)
    );

    pulse_timer u_pulse_timer (.clk, .rst_n, .prm(prm.snk), .gate);

    current_profile u_current_profile (.clk, .rst_n, .prm(prm.snk), .target, .step);

    pulse_driver u_pulse_driver
    (
        .clk, .rst_n, .gate, .target, .step,
        .gate_out, .current_cmd, .pulse_count
    );

    assign running = prm.run;

endmodule

//--- dv/tb_edm_pulse.sv
`timescale 1ns/1ps
`include "edm_consts.svh"

module tb_edm_pulse import edm_pkg::*;;

    localparam int SEL_TON  = 0;
    localparam int SEL_TOFF = 1;
    localparam int SEL_IP   = 2;
    localparam int SEL_WAVE = 3;
    localparam int WAIT_MAX = 100; // cycles before any wait gives up
    localparam int IP_LIMIT = int'(`IP_MAX);

    logic                clk;
    logic                rst_n;
    logic                start_ack, stop_ack, ton_ack, toff_ack, ip_ack, wave_ack;
    logic [`PARAM_W-1:0] ton_async, toff_async, ip_async, wave_async;
    logic                running;
    logic                gate_out;
    logic [`PARAM_W-1:0] current_cmd;
    logic [`PARAM_W-1:0] pulse_count;

    logic [15:0] lfsr = 16'd47576;
    int          errors = 0;
    int          timeouts = 0;

    edm_pulse_top DUT (.*);

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic int rand_width(); // 1..16 from four bits
        int v;
        v = 0;
        repeat (4) v = (v << 1) | int'(lfsr_bit());
        return v + 1;
    endfunction

    task automatic tick(input int n = 1);
        repeat (n) @(posedge clk);
        #2;
    endtask

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp)
        begin
            $display("FAIL at %0t: %s, got %0d expected %0d", $time, msg, got, exp);
            errors++;
        end
    endtask

    task automatic note_timeout(input string what);
        $display("TIMEOUT at %0t: %s", $time, what);
        timeouts++;
    endtask

    task automatic set_ack(input int sel, input logic lvl);
        case (sel)
            SEL_TON:  ton_ack  = lvl;
            SEL_TOFF: toff_ack = lvl;
            SEL_IP:   ip_ack   = lvl;
            default:  wave_ack = lvl;
        endcase
    endtask

    // data stays stable while the ack level is up
    task automatic load_param(input int sel, input logic [`PARAM_W-1:0] val);
        case (sel)
            SEL_TON:  ton_async  = val;
            SEL_TOFF: toff_async = val;
            SEL_IP:   ip_async   = val;
            default:  wave_async = val;
        endcase
        set_ack(sel, 1'b1);
        tick(6);
        set_ack(sel, 1'b0);
        tick(6);
    endtask

    task automatic send_run(input logic start, input logic stop);
        start_ack = start;
        stop_ack  = stop;
        tick(6);
        start_ack = 1'b0;
        stop_ack  = 1'b0;
        tick(6);
    endtask

    task automatic wait_gate(input logic lvl);
        int n;
        n = 0;
        while (gate_out !== lvl && n < WAIT_MAX)
        begin
            tick();
            n++;
        end
        if (gate_out !== lvl)
            note_timeout(lvl ? "gate_out never rose" : "gate_out never fell");
    endtask

    task automatic sync_to_pulse();
        wait_gate(1'b0);
        wait_gate(1'b1);
    endtask

    // starts on the first high cycle and returns on the next one
    task automatic measure_pulse(output int hi, output int lo, input bit cur_chk,
                                 input int cur_hi);
        hi = 0;
        lo = 0;
        while (gate_out === 1'b1 && hi < WAIT_MAX)
        begin
            if (cur_chk)
                check(32'(current_cmd), cur_hi, "current_cmd while gate high");
            hi++;
            tick();
        end
        while (gate_out === 1'b0 && lo < WAIT_MAX)
        begin
            if (cur_chk)
                check(32'(current_cmd), 0, "current_cmd while gate low");
            lo++;
            tick();
        end
        if (hi >= WAIT_MAX || lo >= WAIT_MAX)
            note_timeout("gate_out stopped toggling while a pulse was measured");
    endtask

    task automatic idle_after_reset();
        check(32'(running), 0, "running after reset");
        check(32'(gate_out), 0, "gate_out after reset");
        check(32'(current_cmd), 0, "current_cmd after reset");
        check(32'(pulse_count), 0, "pulse_count after reset");
        repeat (50)
        begin
            check(32'(gate_out), 0, "gate_out without start");
            tick();
        end
    endtask

    task automatic rect_pulse_train();
        int hi;
        int lo;
        int cnt;
        load_param(SEL_TON, 16'd5);
        load_param(SEL_TOFF, 16'd3);
        load_param(SEL_IP, 16'd1000);
        load_param(SEL_WAVE, 16'(WAVE_RECT));
        send_run(1'b1, 1'b0);
        check(32'(running), 1, "running after start");
        sync_to_pulse();
        repeat (4)
        begin
            cnt = int'(pulse_count);
            measure_pulse(hi, lo, 1'b1, 1000); // rect current jumps straight to ip
            check(hi, 5, "rect high width");
            check(lo, 3, "rect low width");
            check(32'(pulse_count), cnt + 1, "pulse_count per pulse");
        end
    endtask

    task automatic ramp_to_clamp();
        int exp_cur;
        int step;
        load_param(SEL_TON, 16'd10);
        load_param(SEL_IP, 16'd6000);
        load_param(SEL_WAVE, 16'(WAVE_RAMP_FAST));
        step = IP_LIMIT >> 2; // ip clamps to the limit before the quarter step
        exp_cur = 0;
        sync_to_pulse();
        repeat (10)
        begin
            exp_cur = (exp_cur + step > IP_LIMIT) ? IP_LIMIT : exp_cur + step;
            check(32'(gate_out), 1, "gate_out during ramp");
            check(32'(current_cmd), exp_cur, "ramp current_cmd");
            tick();
        end
    endtask

    task automatic zero_width_pulses();
        int hi;
        int lo;
        load_param(SEL_TON, 16'd0);
        load_param(SEL_TOFF, 16'd0);
        sync_to_pulse();
        repeat (2)
        begin
            measure_pulse(hi, lo, 1'b0, 0);
            check(hi, 1, "zero ton width");
            check(lo, 1, "zero toff width");
        end
    endtask

    task automatic ton_change_then_stop();
        int hi_w[8];
        int lo_w[8];
        int first_new;
        int n;
        int cnt;
        load_param(SEL_TON, 16'd4);
        load_param(SEL_TOFF, 16'd3);
        sync_to_pulse();
        fork
            load_param(SEL_TON, 16'd7);
            for (int p = 0; p < 8; p++)
                measure_pulse(hi_w[p], lo_w[p], 1'b0, 0);
        join
        first_new = 8;
        for (int p = 7; p >= 0; p--)
            if (hi_w[p] == 7)
                first_new = p;
        check(first_new, 1, "first pulse with the new ton");
        for (int p = 0; p < 8; p++)
        begin
            check(hi_w[p], (p < first_new) ? 4 : 7, "high width around ton change");
            check(lo_w[p], 3, "low width around ton change");
        end
        send_run(1'b1, 1'b1);
        check(32'(running), 1, "running with start and stop together");
        stop_ack = 1'b1;
        n = 0;
        while ((running || gate_out || current_cmd != '0) && n < 6)
        begin
            tick();
            n++;
        end
        check(32'(running), 0, "running after stop");
        check(32'(gate_out), 0, "gate_out after stop");
        check(32'(current_cmd), 0, "current_cmd after stop");
        stop_ack = 1'b0;
        cnt = int'(pulse_count);
        repeat (20)
        begin
            tick();
            check(32'(pulse_count), cnt, "pulse_count held after stop");
        end
    endtask

    task automatic random_width_rounds();
        int ton_w;
        int toff_w;
        int hi;
        int lo;
        send_run(1'b1, 1'b0);
        repeat (8)
        begin
            ton_w  = rand_width();
            toff_w = rand_width();
            load_param(SEL_TON, 16'(ton_w));
            load_param(SEL_TOFF, 16'(toff_w));
            sync_to_pulse();
            repeat (3)
            begin
                measure_pulse(hi, lo, 1'b0, 0);
                check(hi, ton_w, "random high width");
                check(lo, toff_w, "random low width");
            end
        end
    endtask

    initial
    begin
        rst_n      = 1'b0;
        start_ack  = 1'b0;
        stop_ack   = 1'b0;
        ton_ack    = 1'b0;
        toff_ack   = 1'b0;
        ip_ack     = 1'b0;
        wave_ack   = 1'b0;
        ton_async  = '0;
        toff_async = '0;
        ip_async   = '0;
        wave_async = '0;
        repeat (8) @(posedge clk);
        #2 rst_n = 1'b1;
        tick();
        idle_after_reset();
        rect_pulse_train();
        ramp_to_clamp();
        zero_width_pulses();
        ton_change_then_stop();
        random_width_rounds();
        $display("tb_edm_pulse finished: errors=%0d timeouts=%0d", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+design
design/edm_pkg.sv
design/pulse_param_if.sv
design/param_latch.sv
design/param_sync.sv
design/pulse_timer.sv
design/current_profile.sv
design/pulse_driver.sv
design/edm_pulse_top.sv
dv/tb_edm_pulse.sv

//--- Makefile
TOP := tb_edm_pulse

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -o $(TOP)_sim
	./obj_dir/$(TOP)_sim | tee sim.log
	@if grep -q "Test FAILED" sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -q "Test OK" sim.log || { echo "simulation ended without a verdict"; exit 1; }

clean:
	rm -rf obj_dir sim.log
